// File: hdl/mapper_pkg.sv
package mapper_pkg;

	typedef logic [9:0] coord_t;
	typedef logic [2:0] tile_t;
	typedef logic [7:0] channel_t;

	// bullet centre
	typedef struct packed {
		coord_t x;
		coord_t y;
	} point_t;

	// rectangle by centre and half-extents
	typedef struct packed {
		coord_t x;
		coord_t y;
		coord_t half_w;
		coord_t half_h;
	} box_t;

	typedef struct packed {
		channel_t red;
		channel_t green;
		channel_t blue;
	} rgb_t;

	typedef struct packed {
		logic player_bullet;
		logic enemy_bullet;
		logic enemy;
		logic player;
		logic life;
	} layer_hits_t;

	// border is the start screen left edge, draw_x <= 10
	typedef struct packed {
		logic blank;
		logic start;
		logic over;
		logic play;
		logic border;
	} screen_t;

	localparam int N_TILES = 6;

	// sky, water, grass, boulder, wood, leaf
	localparam rgb_t TILE_PALETTE [N_TILES] = '{
		'{8'h40, 8'h90, 8'hf0},
		'{8'h10, 8'h40, 8'hc0},
		'{8'h30, 8'ha0, 8'h30},
		'{8'h80, 8'h70, 8'h60},
		'{8'h70, 8'h40, 8'h18},
		'{8'h20, 8'h70, 8'h20}
	};

	localparam rgb_t COLOR_BLACK  = '{8'h00, 8'h00, 8'h00};
	localparam rgb_t COLOR_WHITE  = '{8'hff, 8'hff, 8'hff};
	localparam rgb_t COLOR_RED    = '{8'hff, 8'h00, 8'h00};
	localparam rgb_t COLOR_ENEMY  = '{8'hd0, 8'h80, 8'h20};
	localparam rgb_t COLOR_PLAYER = '{8'h20, 8'h60, 8'hff};
	localparam rgb_t COLOR_LIFE   = '{8'hff, 8'hc0, 8'h40};
	localparam rgb_t COLOR_START  = '{8'h18, 8'h18, 8'h60};
	localparam rgb_t COLOR_BANNER = '{8'hc0, 8'h20, 8'h20};

	// game-over banner, bounds inclusive
	localparam coord_t BANNER_X0 = 10'd270;
	localparam coord_t BANNER_X1 = 10'd370;
	localparam coord_t BANNER_Y0 = 10'd150;
	localparam coord_t BANNER_Y1 = 10'd225;

endpackage

// File: hdl/pixel_decode.sv
module pixel_decode #(
	parameter int N_BULLETS  = 5,
	parameter int BULLET_R   = 2,
	parameter int LIFE_HALF  = 5,
	parameter int LIFE_PITCH = 20
) (
	input  logic                    pixel_clk,
	input  logic                    arst_n,
	input  logic                    blank,
	input  logic                    start,
	input  logic                    over,
	input  logic                    play,
	input  mapper_pkg::coord_t      draw_x,
	input  mapper_pkg::coord_t      draw_y,
	input  mapper_pkg::tile_t       tile,
	input  mapper_pkg::point_t      bullets [N_BULLETS],
	input  mapper_pkg::point_t      enemy_bullet,
	input  mapper_pkg::box_t        enemy,
	input  logic                    enemy_alive,
	input  mapper_pkg::box_t        player,
	input  logic [1:0]              lives,
	output mapper_pkg::layer_hits_t hits,
	output mapper_pkg::tile_t       tile_q,
	output mapper_pkg::screen_t     screen
);
	import mapper_pkg::*;

	localparam int     R_SQ     = BULLET_R * BULLET_R;
	localparam coord_t LIFE_Y   = coord_t'(20);
	localparam coord_t BORDER_X = coord_t'(10);

	layer_hits_t hits_d;
	logic        border;

	// signed distance a - b, wide enough for the full screen
	function automatic logic signed [10:0] offset(coord_t a, coord_t b);
		return $signed({1'b0, a}) - $signed({1'b0, b});
	endfunction

	function automatic logic in_circle(coord_t px, coord_t py, point_t c);
		logic signed [10:0] dx;
		logic signed [10:0] dy;
		logic [21:0]        d2;
		dx = offset(px, c.x);
		dy = offset(py, c.y);
		d2 = dx * dx + dy * dy;
		return d2 <= 22'(R_SQ);
	endfunction

	function automatic logic in_box(coord_t px, coord_t py, box_t b);
		logic signed [10:0] dx;
		logic signed [10:0] dy;
		logic signed [10:0] hw;
		logic signed [10:0] hh;
		dx = offset(px, b.x);
		dy = offset(py, b.y);
		hw = $signed({1'b0, b.half_w});
		hh = $signed({1'b0, b.half_h});
		return (dx <= hw) && (dx >= -hw) && (dy <= hh) && (dy >= -hh);
	endfunction

	// marker k sits at (k*pitch, 20)
	function automatic box_t life_box(int k);
		box_t b;
		b.x      = coord_t'(k * LIFE_PITCH);
		b.y      = LIFE_Y;
		b.half_w = coord_t'(LIFE_HALF);
		b.half_h = coord_t'(LIFE_HALF);
		return b;
	endfunction

	always_comb begin
		hits_d = '0;
		for (int i = 0; i < N_BULLETS; i++) begin
			if (in_circle(draw_x, draw_y, bullets[i])) begin
				hits_d.player_bullet = 1'b1;
			end
		end
		hits_d.enemy_bullet = in_circle(draw_x, draw_y, enemy_bullet);
		hits_d.enemy        = enemy_alive && in_box(draw_x, draw_y, enemy);
		hits_d.player       = in_box(draw_x, draw_y, player);
		// one marker per lost life
		for (int k = 1; k <= 3; k++) begin
			if ((int'(lives) < 4 - k) && in_box(draw_x, draw_y, life_box(k))) begin
				hits_d.life = 1'b1;
			end
		end
	end

	assign border = (draw_x <= BORDER_X);

	always_ff @(posedge pixel_clk or negedge arst_n) begin
		if (!arst_n) begin
			hits   <= '0;
			tile_q <= '0;
			screen <= '0;
		end else begin
			hits          <= hits_d;
			tile_q        <= tile;
			screen.blank  <= blank;
			screen.start  <= start;
			screen.over   <= over;
			screen.play   <= play;
			screen.border <= border;
		end
	end

endmodule

// File: hdl/layer_compose.sv
module layer_compose (
	input  logic                    pixel_clk,
	input  logic                    arst_n,
	input  mapper_pkg::layer_hits_t hits,
	input  mapper_pkg::tile_t       tile_q,
	input  mapper_pkg::screen_t     screen_in,
	output mapper_pkg::rgb_t        play_color,
	output mapper_pkg::screen_t     screen_out
);
	import mapper_pkg::*;

	rgb_t background;
	rgb_t color_d;

	// tiles past the palette show black
	always_comb begin
		if (tile_q < tile_t'(N_TILES)) begin
			background = TILE_PALETTE[tile_q];
		end else begin
			background = COLOR_BLACK;
		end
	end

	// later layers paint over earlier ones
	always_comb begin
		color_d = background;
		if (hits.player_bullet) begin
			color_d = COLOR_WHITE;
		end
		if (hits.enemy_bullet) begin
			color_d = COLOR_RED;
		end
		if (hits.enemy) begin
			color_d = COLOR_ENEMY;
		end
		if (hits.player) begin
			color_d = COLOR_PLAYER;
		end
		// life markers always on top
		if (hits.life) begin
			color_d = COLOR_LIFE;
		end
	end

	always_ff @(posedge pixel_clk or negedge arst_n) begin
		if (!arst_n) begin
			play_color <= '0;
			screen_out <= '0;
		end else begin
			play_color <= color_d;
			screen_out <= screen_in;
		end
	end

endmodule

// File: hdl/frame_output.sv
module frame_output (
	input  logic                 pixel_clk,
	input  logic                 arst_n,
	input  mapper_pkg::rgb_t     play_color,
	input  mapper_pkg::screen_t  screen,
	input  mapper_pkg::coord_t   draw_x,
	input  mapper_pkg::coord_t   draw_y,
	output mapper_pkg::channel_t red,
	output mapper_pkg::channel_t green,
	output mapper_pkg::channel_t blue
);
	import mapper_pkg::*;

	point_t xy_q [2];
	logic   in_banner;
	rgb_t   pix_d;
	rgb_t   pix_q;

	// align coordinates with the screen state two stages back
	always_ff @(posedge pixel_clk or negedge arst_n) begin
		if (!arst_n) begin
			xy_q[0] <= '0;
			xy_q[1] <= '0;
		end else begin
			xy_q[0].x <= draw_x;
			xy_q[0].y <= draw_y;
			xy_q[1]   <= xy_q[0];
		end
	end

	assign in_banner = (xy_q[1].x >= BANNER_X0) && (xy_q[1].x <= BANNER_X1) &&
		(xy_q[1].y >= BANNER_Y0) && (xy_q[1].y <= BANNER_Y1);

	// blank is active low
	always_comb begin
		if (!screen.blank) begin
			pix_d = COLOR_BLACK;
		end else if (screen.start) begin
			pix_d = screen.border ? COLOR_BLACK : COLOR_START;
		end else if (screen.over) begin
			pix_d = in_banner ? COLOR_BANNER : COLOR_BLACK;
		end else if (screen.play) begin
			pix_d = play_color;
		end else begin
			pix_d = COLOR_BLACK;
		end
	end

	always_ff @(posedge pixel_clk or negedge arst_n) begin
		if (!arst_n) begin
			pix_q <= '0;
		end else begin
			pix_q <= pix_d;
		end
	end

	assign red   = pix_q.red;
	assign green = pix_q.green;
	assign blue  = pix_q.blue;

endmodule

// File: hdl/color_mapper.sv
module color_mapper #(
	parameter int N_BULLETS  = 5,
	parameter int BULLET_R   = 2,
	parameter int LIFE_HALF  = 5,
	parameter int LIFE_PITCH = 20
) (
	input  logic                 pixel_clk,
	input  logic                 arst_n,
	input  logic                 blank,
	input  logic                 start,
	input  logic                 over,
	input  logic                 play,
	input  mapper_pkg::coord_t   draw_x,
	input  mapper_pkg::coord_t   draw_y,
	input  mapper_pkg::tile_t    tile,
	input  mapper_pkg::point_t   bullets [N_BULLETS],
	input  mapper_pkg::point_t   enemy_bullet,
	input  mapper_pkg::box_t     enemy,
	input  logic                 enemy_alive,
	input  mapper_pkg::box_t     player,
	input  logic [1:0]           lives,
	output mapper_pkg::channel_t red,
	output mapper_pkg::channel_t green,
	output mapper_pkg::channel_t blue
);
	import mapper_pkg::*;

	layer_hits_t hits;
	tile_t       tile_q;
	screen_t     screen_dec;
	screen_t     screen_cmp;
	rgb_t        play_color;

	pixel_decode #(
		.N_BULLETS  (N_BULLETS),
		.BULLET_R   (BULLET_R),
		.LIFE_HALF  (LIFE_HALF),
		.LIFE_PITCH (LIFE_PITCH)
	) decode_i (
		.pixel_clk, .arst_n,
		.blank, .start, .over, .play,
		.draw_x, .draw_y, .tile,
		.bullets, .enemy_bullet, .enemy, .enemy_alive, .player, .lives,
		.hits, .tile_q, .screen (screen_dec)
	);

	layer_compose compose_i (
		.pixel_clk, .arst_n,
		.hits, .tile_q,
		.screen_in  (screen_dec),
		.play_color,
		.screen_out (screen_cmp)
	);

	frame_output output_i (
		.pixel_clk, .arst_n,
		.play_color,
		.screen (screen_cmp),
		.draw_x, .draw_y,
		.red, .green, .blue
	);

endmodule

// File: sim/color_mapper_props.sv
module color_mapper_props (
	input logic                 pixel_clk,
	input logic                 arst_n,
	input mapper_pkg::screen_t  screen,
	input mapper_pkg::channel_t red,
	input mapper_pkg::channel_t green,
	input mapper_pkg::channel_t blue
);
	int          fail_count = 0;
	logic [23:0] pixel;

	assign pixel = {red, green, blue};

	// output register clears with the async reset
	reset_black: assert property (@(posedge pixel_clk) !arst_n |-> pixel == 24'h0)
		else begin
			fail_count++;
			$error("outputs not zero while reset is asserted");
		end

	// blank is active low
	blank_black: assert property (@(posedge pixel_clk) disable iff (!arst_n)
		!screen.blank |=> pixel == 24'h0)
		else begin
			fail_count++;
			$error("outputs not black one cycle after blank was low");
		end

	border_black: assert property (@(posedge pixel_clk) disable iff (!arst_n)
		screen.start && screen.border |=> pixel == 24'h0)
		else begin
			fail_count++;
			$error("start screen border not black");
		end

endmodule

bind frame_output color_mapper_props props_i (
	.pixel_clk (pixel_clk),
	.arst_n    (arst_n),
	.screen    (screen),
	.red       (red),
	.green     (green),
	.blue      (blue)
);

// File: sim/color_mapper_tb.sv
module color_mapper_tb;
	import mapper_pkg::*;

	localparam int N_BULLETS    = 5;
	localparam int RESET_CYCLES = 5;
	localparam int LATENCY      = 3;

	localparam rgb_t   GRASS         = TILE_PALETTE[2];
	localparam point_t PARKED_BULLET = '{10'd1010, 10'd1010};

	// stimulus and expected colour of one table row
	typedef struct packed {
		logic       blank;
		logic       start;
		logic       over;
		logic       play;
		coord_t     x;
		coord_t     y;
		tile_t      tile;
		logic [2:0] slot;
		point_t     bullet;
		point_t     enemy_bullet;
		box_t       enemy;
		logic       enemy_alive;
		box_t       player;
		logic [1:0] lives;
		rgb_t       expected;
	} row_t;

	logic     pixel_clk;
	logic     arst_n;
	logic     blank;
	logic     start;
	logic     over;
	logic     play;
	coord_t   draw_x;
	coord_t   draw_y;
	tile_t    tile;
	point_t   bullets [N_BULLETS];
	point_t   enemy_bullet;
	box_t     enemy;
	logic     enemy_alive;
	box_t     player;
	logic [1:0] lives;
	channel_t red;
	channel_t green;
	channel_t blue;

	row_t  rows[$];
	string names[$];
	int    cycle_count = 0;
	int    cycle_limit = 0;

	color_mapper #(.N_BULLETS(N_BULLETS)) dut_i (.*);

	always #10 pixel_clk = ~pixel_clk;

	always @(posedge pixel_clk) begin
		cycle_count <= cycle_count + 1;
		if (dut_i.output_i.props_i.fail_count != 0) begin
			$display("an assertion on the frame_output stage failed");
			$display("Simulation failed");
			$fatal(1);
		end else if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Simulation failed");
			$fatal(1);
		end
	end

	function automatic box_t make_box(coord_t x, coord_t y, coord_t hw, coord_t hh);
		box_t b;
		b.x      = x;
		b.y      = y;
		b.half_w = hw;
		b.half_h = hh;
		return b;
	endfunction

	// every object parked far from the tested pixels
	function automatic row_t screen_row(logic b, logic s, logic o, logic p, coord_t x, coord_t y);
		row_t r;
		r              = '0;
		r.blank        = b;
		r.start        = s;
		r.over         = o;
		r.play         = p;
		r.x            = x;
		r.y            = y;
		r.tile         = 3'd2;
		r.bullet       = PARKED_BULLET;
		r.enemy_bullet = '{10'd1000, 10'd1010};
		r.enemy        = make_box(10'd900, 10'd900, 10'd4, 10'd4);
		r.player       = make_box(10'd800, 10'd800, 10'd4, 10'd4);
		r.lives        = 2'd3;
		return r;
	endfunction

	function automatic row_t play_at(coord_t x, coord_t y, tile_t t);
		row_t r;
		r      = screen_row(1'b1, 1'b0, 1'b0, 1'b1, x, y);
		r.tile = t;
		return r;
	endfunction

	function automatic row_t place_bullet(row_t r, int slot, coord_t cx, coord_t cy);
		r.slot   = 3'(slot);
		r.bullet = '{cx, cy};
		return r;
	endfunction

	function automatic row_t place_enemy_bullet(row_t r, coord_t cx, coord_t cy);
		r.enemy_bullet = '{cx, cy};
		return r;
	endfunction

	function automatic row_t place_enemy(row_t r, box_t b, logic alive);
		r.enemy       = b;
		r.enemy_alive = alive;
		return r;
	endfunction

	function automatic row_t place_player(row_t r, box_t b);
		r.player = b;
		return r;
	endfunction

	function automatic row_t set_lives(row_t r, logic [1:0] n);
		r.lives = n;
		return r;
	endfunction

	task automatic add_row(string name, row_t r, rgb_t expected);
		r.expected = expected;
		rows.push_back(r);
		names.push_back(name);
	endtask

	task automatic apply_row(row_t r);
		blank        <= r.blank;
		start        <= r.start;
		over         <= r.over;
		play         <= r.play;
		draw_x       <= r.x;
		draw_y       <= r.y;
		tile         <= r.tile;
		enemy_bullet <= r.enemy_bullet;
		enemy        <= r.enemy;
		enemy_alive  <= r.enemy_alive;
		player       <= r.player;
		lives        <= r.lives;
		for (int i = 0; i < N_BULLETS; i++) begin
			bullets[i] <= (i == int'(r.slot)) ? r.bullet : PARKED_BULLET;
		end
	endtask

	task automatic check_value(string name, rgb_t expected, rgb_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic build_table();
		box_t ebox;
		ebox = make_box(10'd300, 10'd300, 10'd8, 10'd6);
		add_row("blank_play", place_player(screen_row(0, 0, 0, 1, 300, 300),
			make_box(300, 300, 5, 5)), COLOR_BLACK);
		add_row("blank_start", screen_row(0, 1, 0, 0, 100, 100), COLOR_BLACK);
		add_row("blank_over", screen_row(0, 0, 1, 0, 300, 200), COLOR_BLACK);
		add_row("start_fill", screen_row(1, 1, 0, 0, 11, 100), COLOR_START);
		add_row("start_border", screen_row(1, 1, 0, 0, 10, 100), COLOR_BLACK);
		add_row("start_over_mode", screen_row(1, 1, 1, 0, 300, 200), COLOR_START);
		add_row("banner_top_left", screen_row(1, 0, 1, 0, 270, 150), COLOR_BANNER);
		add_row("banner_bottom_right", screen_row(1, 0, 1, 0, 370, 225), COLOR_BANNER);
		add_row("banner_left_out", screen_row(1, 0, 1, 0, 269, 150), COLOR_BLACK);
		add_row("banner_top_out", screen_row(1, 0, 1, 0, 270, 149), COLOR_BLACK);
		add_row("banner_right_out", screen_row(1, 0, 1, 0, 371, 225), COLOR_BLACK);
		add_row("banner_bottom_out", screen_row(1, 0, 1, 0, 370, 226), COLOR_BLACK);
		add_row("over_before_play", screen_row(1, 0, 1, 1, 100, 100), COLOR_BLACK);
		add_row("no_mode", screen_row(1, 0, 0, 0, 300, 200), COLOR_BLACK);
		for (int t = 0; t < 8; t++) begin
			add_row($sformatf("tile_%0d", t), play_at(200, 300, 3'(t)),
				(t < 6) ? TILE_PALETTE[t] : COLOR_BLACK);
		end
		// bullet radius 2 against the squared distance
		add_row("bullet_d2", place_bullet(play_at(202, 300, 2), 0, 200, 300), COLOR_WHITE);
		add_row("bullet_d3", place_bullet(play_at(203, 300, 2), 0, 200, 300), GRASS);
		add_row("bullet_diag", place_bullet(play_at(201, 301, 2), 4, 200, 300), COLOR_WHITE);
		add_row("bullet_diag_out", place_bullet(play_at(202, 301, 2), 4, 200, 300), GRASS);
		add_row("bullet_left", place_bullet(play_at(198, 300, 2), 2, 200, 300), COLOR_WHITE);
		add_row("enemy_bullet_d2", place_enemy_bullet(play_at(200, 298, 2), 200, 300),
			COLOR_RED);
		add_row("enemy_bullet_on_bullet", place_enemy_bullet(
			place_bullet(play_at(200, 300, 2), 1, 200, 301), 200, 300), COLOR_RED);
		add_row("enemy_dead", place_enemy(play_at(300, 300, 2), ebox, 0), GRASS);
		add_row("enemy_alive", place_enemy(play_at(300, 300, 2), ebox, 1), COLOR_ENEMY);
		add_row("enemy_corner_hi", place_enemy(play_at(308, 306, 2), ebox, 1), COLOR_ENEMY);
		add_row("enemy_corner_lo", place_enemy(play_at(292, 294, 2), ebox, 1), COLOR_ENEMY);
		add_row("enemy_outside", place_enemy(play_at(309, 300, 2), ebox, 1), GRASS);
		add_row("enemy_on_bullet", place_enemy(
			place_bullet(play_at(300, 300, 2), 0, 300, 300), ebox, 1), COLOR_ENEMY);
		add_row("player_on_enemy", place_player(place_enemy(play_at(302, 300, 2), ebox, 1),
			make_box(305, 300, 5, 5)), COLOR_PLAYER);
		add_row("player_alone", place_player(play_at(100, 400, 2), make_box(100, 400, 3, 3)),
			COLOR_PLAYER);
		// markers at x = 20, 40, 60 with y = 20
		add_row("lives3_marker1", play_at(20, 20, 2), GRASS);
		add_row("lives1_marker1", set_lives(play_at(20, 20, 2), 1), COLOR_LIFE);
		add_row("lives1_marker2", set_lives(play_at(40, 20, 2), 1), COLOR_LIFE);
		add_row("lives1_marker3", set_lives(play_at(60, 20, 2), 1), GRASS);
		add_row("lives0_marker3", set_lives(play_at(60, 20, 2), 0), COLOR_LIFE);
		add_row("lives2_marker1_edge", set_lives(play_at(25, 25, 2), 2), COLOR_LIFE);
		add_row("lives2_marker1_out", set_lives(play_at(26, 20, 2), 2), GRASS);
		add_row("lives2_marker2", set_lives(play_at(40, 20, 2), 2), GRASS);
		add_row("life_on_player", place_player(set_lives(play_at(40, 20, 2), 1),
			make_box(40, 20, 10, 10)), COLOR_LIFE);
	endtask

	initial begin
		int n;
		pixel_clk    = 1'b0;
		arst_n       = 1'b1;
		blank        = 1'b0;
		start        = 1'b0;
		over         = 1'b0;
		play         = 1'b0;
		draw_x       = '0;
		draw_y       = '0;
		tile         = '0;
		enemy_bullet = '0;
		enemy        = '0;
		enemy_alive  = 1'b0;
		player       = '0;
		lives        = '0;
		for (int i = 0; i < N_BULLETS; i++) begin
			bullets[i] = '0;
		end

		build_table();
		n = rows.size();
		cycle_limit = n + RESET_CYCLES + LATENCY + 20;

		@(posedge pixel_clk);
		arst_n <= 1'b0;
		repeat (RESET_CYCLES) @(posedge pixel_clk);
		arst_n <= 1'b1;

		// row i comes out LATENCY cycles after it is driven
		for (int i = 0; i < n + LATENCY; i++) begin
			@(posedge pixel_clk);
			if (i < n) begin
				apply_row(rows[i]);
			end
			@(negedge pixel_clk);
			if (i >= LATENCY) begin
				check_value(names[i - LATENCY], rows[i - LATENCY].expected, {red, green, blue});
			end else begin
				check_value("post_reset", COLOR_BLACK, {red, green, blue});
			end
		end

		if (dut_i.output_i.props_i.fail_count == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			$display("assertion failures: %0d", dut_i.output_i.props_i.fail_count);
			$display("Simulation failed");
			$fatal(1);
		end
	end

endmodule

// File: compile.f
hdl/mapper_pkg.sv
hdl/pixel_decode.sv
hdl/layer_compose.sv
hdl/frame_output.sv
hdl/color_mapper.sv
sim/color_mapper_props.sv
sim/color_mapper_tb.sv
